// File: vlog.f
+incdir+source
source/rw_gen_pkg.sv
source/rw_gen_control.sv
source/rw_address_unit.sv
source/pending_fifo.sv
source/rw_response_merge.sv
source/rw_generator_top.sv
testbench/rw_generator_tb.sv

// File: run_verilator.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module rw_generator_tb || exit 1
sim_out=$(./obj_dir/Vrw_generator_tb 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST PASSED" && exit 0 || exit 1

// File: testbench/rw_generator_tb.sv
// Memory model answers in order after 1 to 4 cycles; stimulus keeps at most 8 requests in flight
`include "rw_gen_macros.svh"

module rw_generator_tb
    import rw_gen_pkg::*;
();

    localparam logic [31:0]           SEED           = 32'h955063c4;
    localparam logic [`RW_ADDR_W-1:0] READ_XOR       = 32'h5a5a_c3c3;
    localparam int                    NUM_COMMANDS   = 64;
    localparam int                    MAX_IN_FLIGHT  = 8;
    // Two phases of 64 commands at up to 6 cycles each, plus reset and margin
    localparam int                    TIMEOUT_CYCLES = 2000;

    logic           ap_clk;
    logic           areset_generator;
    logic           cfg_valid;
    rw_cfg_t        cfg;
    logic           cmd_valid;
    engine_cmd_t    cmd;
    logic           rsp_valid;
    mem_rsp_t       rsp;
    logic           req_valid;
    mem_req_t       req;
    logic           result_valid;
    engine_result_t result;
    logic           done;

    rw_cfg_t               cur_cfg;
    logic                  cmd_live;
    logic                  expect_idle;
    string                 test_name;
    mem_req_t              exp_req_q[$];
    engine_result_t        exp_res_q[$];
    int                    req_idx;
    int                    res_idx;
    logic [`RW_ADDR_W-1:0] mem_addr_q[$];
    int                    mem_due_q[$];
    int                    mem_rd_idx;
    int                    cycle;
    int                    outstanding_model;
    logic                  accepting_model;
    logic                  req_expected;
    logic                  result_expected;
    logic                  done_exp;
    int                    value_errors;
    int                    timing_errors;

    rw_generator_top i_dut (.*);

    always begin
        ap_clk = 1'b0;
        #2;
        ap_clk = 1'b1;
        #2;
    end

    // ------------------------------------------------------------------------
    // Strobe timing
    // ------------------------------------------------------------------------
    task automatic flag_timing_error(input string sig, input logic expected);
        timing_errors++;
        $display("** Error [%s] %s: expected %0b, actual %0b", test_name, sig, expected, !expected);
    endtask

    a_idle: assert property (@(posedge ap_clk) disable iff (areset_generator)
        expect_idle |-> !req_valid && !done) else flag_timing_error("req_valid|done", 1'b0);
    a_cmd_gives_req: assert property (@(posedge ap_clk) disable iff (areset_generator)
        (cmd_valid && cmd_live) |=> req_valid) else flag_timing_error("req_valid", 1'b1);
    a_no_stray_req: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(cmd_valid && cmd_live) |=> !req_valid) else flag_timing_error("req_valid", 1'b0);
    a_rsp_gives_result: assert property (@(posedge ap_clk) disable iff (areset_generator)
        rsp_valid |=> result_valid) else flag_timing_error("result_valid", 1'b1);
    a_no_stray_result: assert property (@(posedge ap_clk) disable iff (areset_generator)
        !rsp_valid |=> !result_valid) else flag_timing_error("result_valid", 1'b0);

    // ------------------------------------------------------------------------
    // Value checks against the expected queues
    // ------------------------------------------------------------------------
    always @(posedge ap_clk) begin
        mem_req_t       exp_req;
        engine_result_t exp_res;
        if (areset_generator) begin
            outstanding_model = 0;
            accepting_model   = 1'b0;
            req_expected      = 1'b0;
            result_expected   = 1'b0;
            done_exp          = 1'b0;
        end else begin
            a_done: assert (done == done_exp) else begin
                value_errors++;
                $display("** Error [%s] done: expected %0b, actual %0b",
                         test_name, done_exp, done);
            end
            // Done follows last cycle's accept state and count
            done_exp           = accepting_model && (outstanding_model == 0);
            accepting_model    = accepting_model || cfg_valid;
            outstanding_model += int'(req_expected) - int'(result_expected);
            // Strobes due next cycle from the stimulus driven in this one
            req_expected       = cmd_valid && cmd_live;
            result_expected    = rsp_valid;
            if (req_valid) begin
                exp_req = exp_req_q[req_idx];
                a_request: assert (req.write == exp_req.write && req.address == exp_req.address
                                   && (!exp_req.write || req.data == exp_req.data)) else begin
                    value_errors++;
                    $display("** Error [%s] request %0d: expected %h, actual %h",
                             test_name, req_idx, exp_req, req);
                end
                req_idx++;
            end
            if (result_valid) begin
                exp_res = exp_res_q[res_idx];
                a_result: assert (result == exp_res) else begin
                    value_errors++;
                    $display("** Error [%s] result %0d: expected %h, actual %h",
                             test_name, res_idx, exp_res, result);
                end
                res_idx++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------------------
    always @(posedge ap_clk) begin
        if (!areset_generator && req_valid) begin
            mem_addr_q.push_back(req.address);
            mem_due_q.push_back(cycle + int'($urandom_range(1, 4)));
        end
    end

    // Answers strictly in order, even when a later request is already due
    initial begin
        rsp_valid = 1'b0;
        rsp       = '0;
        forever begin
            @(negedge ap_clk);
            rsp_valid = 1'b0;
            if (mem_rd_idx < mem_addr_q.size() && cycle >= mem_due_q[mem_rd_idx]) begin
                rsp_valid = 1'b1;
                rsp.data  = mem_addr_q[mem_rd_idx] ^ READ_XOR;
                mem_rd_idx++;
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic apply_config(input rw_cfg_t new_cfg);
        cfg_valid = 1'b1;
        cfg       = new_cfg;
        @(negedge ap_clk);
        cfg_valid = 1'b0;
        cur_cfg   = new_cfg;
        cmd_live  = 1'b1;
    endtask

    task automatic issue_command(input logic record);
        engine_cmd_t           c;
        logic [`RW_ADDR_W-1:0] addr;
        logic                  wr;
        while (exp_res_q.size() - res_idx >= MAX_IN_FLIGHT) begin
            @(negedge ap_clk);
        end
        c.index   = `RW_INDEX_W'($urandom);
        c.data    = $urandom;
        c.tag     = `RW_TAG_W'(exp_res_q.size());
        addr      = cur_cfg.base_address + (`RW_ADDR_W'(c.index) << cur_cfg.index_shift);
        wr        = (cur_cfg.mode == RW_MODE_WRITE);
        cmd_valid = 1'b1;
        cmd       = c;
        if (record) begin
            exp_req_q.push_back(mem_req_t'{write: wr, address: addr, data: c.data});
            exp_res_q.push_back(engine_result_t'{tag: c.tag, destination: cur_cfg.destination,
                                                 data: wr ? c.data : addr ^ READ_XOR});
        end
        @(negedge ap_clk);
        cmd_valid = 1'b0;
        if ($urandom_range(0, 1) == 0) begin
            @(negedge ap_clk);
        end
    endtask

    task automatic wait_until_drained();
        while (res_idx < exp_res_q.size() || !done) begin
            @(negedge ap_clk);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        areset_generator = 1'b1;
        cfg_valid        = 1'b0;
        cfg              = '0;
        cmd_valid        = 1'b0;
        cmd              = '0;
        cur_cfg          = '0;
        cmd_live         = 1'b0;
        expect_idle      = 1'b0;
        test_name        = "reset";
        repeat (10) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator = 1'b0;

        // Commands before any configuration must be dropped
        test_name   = "unconfigured";
        expect_idle = 1'b1;
        repeat (4) issue_command(1'b0);
        @(negedge ap_clk);
        expect_idle = 1'b0;

        test_name = "read_mode";
        apply_config(rw_cfg_t'{base_address: 32'h1000_0000, index_shift: 3'd3,
                               mode: RW_MODE_READ, destination: 4'h5});
        repeat (NUM_COMMANDS) issue_command(1'b1);
        wait_until_drained();

        test_name = "write_mode";
        apply_config(rw_cfg_t'{base_address: 32'h2000_0040, index_shift: 3'd2,
                               mode: RW_MODE_WRITE, destination: 4'ha});
        repeat (NUM_COMMANDS) issue_command(1'b1);
        wait_until_drained();

        $display("Value errors: %0d, timing errors: %0d", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : rw_generator_tb

// File: source/rw_generator_top.sv
// One lane, no back-pressure: the user bounds outstanding requests and answers them in order
`include "rw_gen_macros.svh"

module rw_generator_top
    import rw_gen_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_generator,
    input  logic           cfg_valid,
    input  rw_cfg_t        cfg,
    input  logic           cmd_valid,
    input  engine_cmd_t    cmd,
    input  logic           rsp_valid,
    input  mem_rsp_t       rsp,
    output logic           req_valid,
    output mem_req_t       req,
    output logic           result_valid,
    output engine_result_t result,
    output logic           done
);

    logic     accepting;
    rw_cfg_t  cfg_held;
    logic     push;
    pending_t push_entry;
    logic     pop;
    pending_t head;

    rw_gen_control i_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg              (cfg),
        .req_valid        (req_valid),
        .result_valid     (result_valid),
        .accepting        (accepting),
        .cfg_held         (cfg_held),
        .done             (done)
    );

    rw_address_unit i_address_unit (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .accepting        (accepting),
        .cfg_held         (cfg_held),
        .cmd_valid        (cmd_valid),
        .cmd              (cmd),
        .req_valid        (req_valid),
        .req              (req),
        .push             (push),
        .push_entry       (push_entry)
    );

    // Queue status is only checked inside the FIFO itself
    pending_fifo #(
        .DEPTH (`RW_PENDING_DEPTH)
    ) i_pending_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .push_entry       (push_entry),
        .pop              (pop),
        .head             (head),
        .empty            (),
        .full             ()
    );

    rw_response_merge i_response_merge (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .mode             (cfg_held.mode),
        .destination      (cfg_held.destination),
        .rsp_valid        (rsp_valid),
        .rsp              (rsp),
        .head             (head),
        .pop              (pop),
        .result_valid     (result_valid),
        .result           (result)
    );

endmodule : rw_generator_top

// File: source/rw_response_merge.sv
// Responses must arrive in request order; the head entry is trusted to match the response
`include "rw_gen_macros.svh"

module rw_response_merge
    import rw_gen_pkg::*;
(
    input  logic                  ap_clk,
    input  logic                  areset_generator,
    input  rw_mode_t              mode,
    input  logic [`RW_DEST_W-1:0] destination,
    input  logic                  rsp_valid,
    input  mem_rsp_t              rsp,
    input  pending_t              head,
    output logic                  pop,
    output logic                  result_valid,
    output engine_result_t        result
);

    // Each response retires exactly one pending entry
    assign pop = rsp_valid;

    // ---------------------------------------------------------------------------
    // Result register
    // ---------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= rsp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rsp_valid) begin
            result.tag         <= head.tag;
            result.destination <= destination;
            // Write mode acknowledges with the original command data
            if (mode == RW_MODE_READ) begin
                result.data <= rsp.data;
            end else begin
                result.data <= head.data;
            end
        end
    end

endmodule : rw_response_merge

// File: source/pending_fifo.sv
// DEPTH must be a power of two; no back-pressure, the user keeps pushes within DEPTH
`include "rw_gen_macros.svh"

module pending_fifo
    import rw_gen_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     push,
    input  pending_t push_entry,
    input  logic     pop,
    output pending_t head,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    pending_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;

    // ---------------------------------------------------------------------------
    // Storage
    // ---------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (fill == '0);
    assign full  = (fill == CNT_W'(DEPTH));

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // ---------------------------------------------------------------------------
    // Checks
    // ---------------------------------------------------------------------------
    a_no_overflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        push |-> (!full || pop)
    ) else $error("pending queue overflow");

    a_no_underflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        pop |-> !empty
    ) else $error("memory response with no pending entry");

endmodule : pending_fifo

// File: source/rw_address_unit.sv
// Commands are dropped, not held, while unconfigured; the address wraps at RW_ADDR_W bits
`include "rw_gen_macros.svh"

module rw_address_unit
    import rw_gen_pkg::*;
(
    input  logic        ap_clk,
    input  logic        areset_generator,
    input  logic        accepting,
    input  rw_cfg_t     cfg_held,
    input  logic        cmd_valid,
    input  engine_cmd_t cmd,
    output logic        req_valid,
    output mem_req_t    req,
    output logic        push,
    output pending_t    push_entry
);

    logic                  accept;
    logic                  is_write;
    logic [`RW_ADDR_W-1:0] offset;

    assign accept   = accepting && cmd_valid;
    assign is_write = (cfg_held.mode == RW_MODE_WRITE);

    // Index widened before the shift so no high bits are lost
    assign offset = {{(`RW_ADDR_W-`RW_INDEX_W){1'b0}}, cmd.index} << cfg_held.index_shift;

    // ---------------------------------------------------------------------------
    // Request register
    // ---------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (accept) begin
            req.write   <= is_write;
            req.address <= cfg_held.base_address + offset;
            req.data    <= is_write ? cmd.data : '0;
        end
    end

    // Queue write lands on the same edge that raises req_valid
    assign push       = accept;
    assign push_entry = '{tag: cmd.tag, data: cmd.data};

endmodule : rw_address_unit

// File: source/rw_gen_control.sv
// Reconfigure only with no request outstanding; responses must never outnumber requests
`include "rw_gen_macros.svh"

module rw_gen_control
    import rw_gen_pkg::*;
(
    input  logic    ap_clk,
    input  logic    areset_generator,
    input  logic    cfg_valid,
    input  rw_cfg_t cfg,
    input  logic    req_valid,
    input  logic    result_valid,
    output logic    accepting,
    output rw_cfg_t cfg_held,
    output logic    done
);

    logic [`RW_COUNT_W-1:0] outstanding;
    logic [`RW_COUNT_W-1:0] outstanding_next;

    // ---------------------------------------------------------------------------
    // Configuration register and accept state
    // ---------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (cfg_valid) begin
            cfg_held <= cfg;
        end
    end

    // Stays high once the first configuration has landed
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            accepting <= 1'b0;
        end else if (cfg_valid) begin
            accepting <= 1'b1;
        end
    end

    // ---------------------------------------------------------------------------
    // Outstanding request counter
    // ---------------------------------------------------------------------------
    always_comb begin
        outstanding_next = outstanding;
        case ({req_valid, result_valid})
            2'b10:   outstanding_next = outstanding + 1'b1;
            2'b01:   outstanding_next = outstanding - 1'b1;
            default: outstanding_next = outstanding;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
            done        <= 1'b0;
        end else begin
            outstanding <= outstanding_next;
            // Looks at last cycle's count, so done trails the final result
            done        <= accepting && (outstanding == '0);
        end
    end

    // ---------------------------------------------------------------------------
    // Checks
    // ---------------------------------------------------------------------------
    // A request already issued under the old settings must drain first
    a_cfg_when_idle: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        cfg_valid |-> (outstanding == '0) && !req_valid
    ) else $error("reconfiguration with requests outstanding");

    // Results come from the merge unit, requests from the address unit
    a_no_underflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        (result_valid && !req_valid) |-> (outstanding != '0)
    ) else $error("result without an outstanding request");

endmodule : rw_gen_control

// File: source/rw_gen_pkg.sv
// Shared packed types; field widths come from the macros header and must stay in step with it
`include "rw_gen_macros.svh"

package rw_gen_pkg;

    // ---------------------------------------------------------------------------
    // Configuration
    // ---------------------------------------------------------------------------
    typedef enum logic {
        RW_MODE_READ  = 1'b0,
        RW_MODE_WRITE = 1'b1
    } rw_mode_t;

    typedef struct packed {
        logic [`RW_ADDR_W-1:0]  base_address;
        logic [`RW_SHIFT_W-1:0] index_shift;
        rw_mode_t               mode;
        logic [`RW_DEST_W-1:0]  destination;
    } rw_cfg_t;

    // ---------------------------------------------------------------------------
    // Engine and memory transfers
    // ---------------------------------------------------------------------------
    typedef struct packed {
        logic [`RW_INDEX_W-1:0] index;
        logic [`RW_DATA_W-1:0]  data;
        logic [`RW_TAG_W-1:0]   tag;
    } engine_cmd_t;

    typedef struct packed {
        logic                  write;
        logic [`RW_ADDR_W-1:0] address;
        logic [`RW_DATA_W-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic [`RW_DATA_W-1:0] data;
    } mem_rsp_t;

    // Parked per request until its response returns
    typedef struct packed {
        logic [`RW_TAG_W-1:0]  tag;
        logic [`RW_DATA_W-1:0] data;
    } pending_t;

    typedef struct packed {
        logic [`RW_TAG_W-1:0]  tag;
        logic [`RW_DEST_W-1:0] destination;
        logic [`RW_DATA_W-1:0] data;
    } engine_result_t;

endpackage : rw_gen_pkg

// File: source/rw_gen_macros.svh
// Widths and depths for the generator; RW_COUNT_W must hold RW_PENDING_DEPTH, depth a power of two
`ifndef RW_GEN_MACROS_SVH
`define RW_GEN_MACROS_SVH

// ---------------------------------------------------------------------------
// Datapath widths
// ---------------------------------------------------------------------------
`define RW_ADDR_W   32
`define RW_DATA_W   32
`define RW_INDEX_W  16
`define RW_SHIFT_W  3
`define RW_TAG_W    8
`define RW_DEST_W   4

// ---------------------------------------------------------------------------
// Pending queue sizing
// ---------------------------------------------------------------------------
`define RW_PENDING_DEPTH 16
// Must reach RW_PENDING_DEPTH without wrapping
`define RW_COUNT_W       5

`endif
